//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  fabPkg::Word  a,
	input  fabPkg::Word  b,
	input  fabPkg::AluOp op,
	output fabPkg::Word  result
);
	import fabPkg::*;

	logic lessThan;

	// Signed compare for SLT
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

endmodule

//--- build.f
fabPkg.sv
alu.sv
controlUnit.sv
hazardUnit.sv
registerFile.sv
instrMemory.sv
dataMemory.sv
mipsPipeline.sv
tbMipsPipeline.sv

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  fabPkg::Word  instr,
	output logic         regDst,
	output logic         aluSrc,
	output fabPkg::AluOp aluOp,
	output logic         memWrite,
	output logic         memToReg,
	output logic         regWrite,
	output logic         branch,
	output logic         branchNe,
	output logic         jump,
	output logic         eop
);
	import fabPkg::*;

	Opcode opcode;
	Funct funct;

	assign opcode = Opcode'(instr[31:26]);
	assign funct = Funct'(instr[5:0]);

	always_comb begin
		// Defaults give a no-op
		regDst = 1'b0;
		aluSrc = 1'b0;
		aluOp = aluAdd;
		memWrite = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		branch = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		eop = 1'b0;
		case (opcode)
			opRtype: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					// Also catches the all-zero bubble
					default: regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			opLw: begin
				aluSrc = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			opSw: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			opBeq: branch = 1'b1;
			opBne: begin
				branch = 1'b1;
				branchNe = 1'b1;
			end
			opJ: jump = 1'b1;
			opEop: eop = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int dmemDepth = 256
) (
	input  logic        clk,
	input  logic        writeEn,
	input  fabPkg::Pc   addr,
	input  fabPkg::Word writeData,
	output fabPkg::Word readData
);
	import fabPkg::*;

	Word mem [dmemDepth] = '{default: '0};

	// Whole-word store
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[addr] <= writeData;
		end
	end

	// Load data is ready in the same cycle
	assign readData = mem[addr];

endmodule

//--- fabPkg.sv
package fabPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// Word address, 256 words of program and data
	localparam int pcWidth = 8;

	typedef logic [dataWidth-1:0] Word;
	typedef logic [regAddrWidth-1:0] RegAddr;
	typedef logic [pcWidth-1:0] Pc;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	// Opcode field, bits 31:26
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b,
		opEop   = 6'h3f
	} Opcode;

	// Funct field for R-type, bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnXor = 6'h26,
		fnSlt = 6'h2a
	} Funct;

	////////////////////////////////////////////////////////////
	// Datapath selects
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluSlt = 3'd5
	} AluOp;

	// EX operand source
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdWb   = 2'd1,
		fwdMem  = 2'd2
	} FwdSel;

endpackage

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  fabPkg::RegAddr rsId,
	input  fabPkg::RegAddr rtId,
	input  fabPkg::RegAddr rsEx,
	input  fabPkg::RegAddr rtEx,
	input  fabPkg::RegAddr writeRegEx,
	input  fabPkg::RegAddr writeRegMem,
	input  fabPkg::RegAddr writeRegWb,
	input  logic           regWriteEx,
	input  logic           regWriteMem,
	input  logic           regWriteWb,
	input  logic           memToRegEx,
	input  logic           memToRegMem,
	input  logic           branchId,
	input  logic           eopId,
	output logic           stallFetch,
	output logic           flushEx,
	output logic           fwdBranchA,
	output logic           fwdBranchB,
	output fabPkg::FwdSel  fwdA,
	output fabPkg::FwdSel  fwdB
);
	import fabPkg::*;

	logic exHitsId;
	logic memHitsId;
	logic loadUse;
	logic branchWait;

	// A live write to a real register that matches the source
	function automatic logic hits(RegAddr dst, logic we, RegAddr src);
		return we && (dst != '0) && (dst == src);
	endfunction

	function automatic FwdSel pickFwd(RegAddr src);
		if (hits(writeRegMem, regWriteMem, src)) begin
			return fwdMem;
		end else if (hits(writeRegWb, regWriteWb, src)) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	assign exHitsId = hits(writeRegEx, regWriteEx, rsId) || hits(writeRegEx, regWriteEx, rtId);
	assign memHitsId = hits(writeRegMem, regWriteMem, rsId) || hits(writeRegMem, regWriteMem, rtId);

	// Load in EX, consumer in ID
	assign loadUse = memToRegEx && exHitsId && !eopId;
	// Branch compares in ID, so it waits for any EX result and for a load in MEM
	assign branchWait = branchId && (exHitsId || (memToRegMem && memHitsId));

	assign flushEx = loadUse || branchWait;
	assign stallFetch = flushEx || eopId;

	assign fwdBranchA = hits(writeRegMem, regWriteMem, rsId) && !memToRegMem;
	assign fwdBranchB = hits(writeRegMem, regWriteMem, rtId) && !memToRegMem;

	assign fwdA = pickFwd(rsEx);
	assign fwdB = pickFwd(rtEx);

endmodule

//--- instrMemory.sv
`timescale 1ns/1ps

module instrMemory #(
	parameter int imemDepth = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        loadReq,
	input  fabPkg::Pc   loadAddr,
	input  fabPkg::Word loadData,
	output logic        loadAck,
	input  fabPkg::Pc   fetchAddr,
	output fabPkg::Word instr
);
	import fabPkg::*;

	// Unloaded words read as zero, which decodes as a no-op
	Word mem [imemDepth] = '{default: '0};
	logic writePhase;

	// Request seen and not yet acknowledged
	assign writePhase = loadReq && !loadAck && !rst;

	always_ff @(posedge clk) begin
		if (writePhase) begin
			mem[loadAddr] <= loadData;
		end
	end

	// Four-phase ack: rise after the write, fall once req drops
	always_ff @(posedge clk) begin
		if (rst) begin
			loadAck <= 1'b0;
		end else if (writePhase) begin
			loadAck <= 1'b1;
		end else if (!loadReq && loadAck) begin
			loadAck <= 1'b0;
		end
	end

	// Asynchronous fetch
	assign instr = mem[fetchAddr];

endmodule

//--- mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           loadReq,
	input  fabPkg::Pc      loadAddr,
	input  fabPkg::Word    loadData,
	output logic           loadAck,
	input  logic           start,
	output logic           halted,
	input  fabPkg::RegAddr dbgRegAddr,
	output fabPkg::Word    dbgRegData
);
	import fabPkg::*;

	logic running;
	logic fetchDone;

	// Fetch
	Pc pc;
	Pc pcPlusOne;
	Word instrIf;

	// Decode
	Word instrId;
	Pc pcPlusOneId;
	Pc branchTarget;
	RegAddr rsId;
	RegAddr rtId;
	Word immId;
	Word readDataA;
	Word readDataB;
	Word branchA;
	Word branchB;
	logic regDstId, aluSrcId, memWriteId, memToRegId, regWriteId;
	logic branchId, branchNeId, jumpId, eopId;
	AluOp aluOpId;
	logic branchTaken;
	logic redirect;

	// Hazard decisions
	logic stallFetch;
	logic flushEx;
	logic fwdBranchA;
	logic fwdBranchB;
	FwdSel fwdA;
	FwdSel fwdB;

	// Execute
	logic regDstEx, aluSrcEx, memWriteEx, memToRegEx, regWriteEx, eopEx;
	AluOp aluOpEx;
	Word readAEx;
	Word readBEx;
	Word immEx;
	RegAddr rsEx;
	RegAddr rtEx;
	RegAddr rdEx;
	RegAddr writeRegEx;
	Word srcA;
	Word srcB;
	Word aluOut;

	// Memory and writeback
	logic memWriteMem, memToRegMem, regWriteMem, eopMem;
	RegAddr writeRegMem;
	Word aluOutMem;
	Word writeDataMem;
	Word readDataMem;
	logic memToRegWb, regWriteWb, eopWb;
	RegAddr writeRegWb;
	Word aluOutWb;
	Word readDataWb;
	Word resultWb;

	function automatic Word pickOperand(FwdSel sel, Word regVal, Word memVal, Word wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			halted <= 1'b0;
		end else if (running && eopWb) begin
			// EOP retires
			running <= 1'b0;
			halted <= 1'b1;
		end else if (start && !halted) begin
			running <= 1'b1;
		end
	end

	// Fetch stays frozen once EOP has moved past ID
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchDone <= 1'b0;
		end else if (running && eopId && !flushEx) begin
			fetchDone <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////
	assign pcPlusOne = pc + Pc'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (running) begin
			if (redirect) begin
				pc <= branchTarget;
			end else if (!stallFetch && !fetchDone) begin
				pc <= pcPlusOne;
			end
		end
	end

	instrMemory #(
		.imemDepth(imemDepth)
	) u_instrMemory (
		.clk(clk),
		.rst(rst),
		.loadReq(loadReq),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.loadAck(loadAck),
		.fetchAddr(pc),
		.instr(instrIf)
	);

	// IF/ID, an all-zero instruction is a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			instrId <= '0;
		end else if (running && !flushEx) begin
			if (redirect || eopId || fetchDone) begin
				instrId <= '0;
			end else begin
				instrId <= instrIf;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (running && !flushEx) begin
			pcPlusOneId <= pcPlusOne;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode and branch resolution
	////////////////////////////////////////////////////////////
	assign rsId = instrId[25:21];
	assign rtId = instrId[20:16];
	assign immId = {{(dataWidth-16){instrId[15]}}, instrId[15:0]};

	controlUnit u_controlUnit (
		.instr(instrId),
		.regDst(regDstId),
		.aluSrc(aluSrcId),
		.aluOp(aluOpId),
		.memWrite(memWriteId),
		.memToReg(memToRegId),
		.regWrite(regWriteId),
		.branch(branchId),
		.branchNe(branchNeId),
		.jump(jumpId),
		.eop(eopId)
	);

	registerFile u_registerFile (
		.clk(clk),
		.rst(rst),
		.writeEn(regWriteWb && running),
		.writeAddr(writeRegWb),
		.writeData(resultWb),
		.readAddrA(rsId),
		.readAddrB(rtId),
		.dbgAddr(dbgRegAddr),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.dbgData(dbgRegData)
	);

	hazardUnit u_hazardUnit (
		.rsId(rsId),
		.rtId(rtId),
		.rsEx(rsEx),
		.rtEx(rtEx),
		.writeRegEx(writeRegEx),
		.writeRegMem(writeRegMem),
		.writeRegWb(writeRegWb),
		.regWriteEx(regWriteEx),
		.regWriteMem(regWriteMem),
		.regWriteWb(regWriteWb),
		.memToRegEx(memToRegEx),
		.memToRegMem(memToRegMem),
		.branchId(branchId),
		.eopId(eopId),
		.stallFetch(stallFetch),
		.flushEx(flushEx),
		.fwdBranchA(fwdBranchA),
		.fwdBranchB(fwdBranchB),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	assign branchA = fwdBranchA ? aluOutMem : readDataA;
	assign branchB = fwdBranchB ? aluOutMem : readDataB;
	assign branchTaken = branchId && (branchNeId ? (branchA != branchB) : (branchA == branchB));
	// Branch and jump targets are both PC+1 relative
	assign branchTarget = pcPlusOneId + immId[pcWidth-1:0];
	assign redirect = (branchTaken || jumpId) && !flushEx;

	// ID/EX controls, a stall turns this slot into a bubble
	always_ff @(posedge clk) begin
		if (rst || (running && flushEx)) begin
			regDstEx <= 1'b0;
			aluSrcEx <= 1'b0;
			aluOpEx <= aluAdd;
			memWriteEx <= 1'b0;
			memToRegEx <= 1'b0;
			regWriteEx <= 1'b0;
			eopEx <= 1'b0;
			rsEx <= '0;
			rtEx <= '0;
			rdEx <= '0;
		end else if (running) begin
			regDstEx <= regDstId;
			aluSrcEx <= aluSrcId;
			aluOpEx <= aluOpId;
			memWriteEx <= memWriteId;
			memToRegEx <= memToRegId;
			regWriteEx <= regWriteId;
			eopEx <= eopId;
			rsEx <= rsId;
			rtEx <= rtId;
			rdEx <= instrId[15:11];
		end
	end

	always_ff @(posedge clk) begin
		if (running) begin
			readAEx <= readDataA;
			readBEx <= readDataB;
			immEx <= immId;
		end
	end

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	assign srcA = pickOperand(fwdA, readAEx, aluOutMem, resultWb);
	assign srcB = pickOperand(fwdB, readBEx, aluOutMem, resultWb);
	assign writeRegEx = regDstEx ? rdEx : rtEx;

	alu u_alu (
		.a(srcA),
		.b(aluSrcEx ? immEx : srcB),
		.op(aluOpEx),
		.result(aluOut)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			memWriteMem <= 1'b0;
			memToRegMem <= 1'b0;
			regWriteMem <= 1'b0;
			eopMem <= 1'b0;
			writeRegMem <= '0;
		end else if (running) begin
			memWriteMem <= memWriteEx;
			memToRegMem <= memToRegEx;
			regWriteMem <= regWriteEx;
			eopMem <= eopEx;
			writeRegMem <= writeRegEx;
		end
	end

	always_ff @(posedge clk) begin
		if (running) begin
			aluOutMem <= aluOut;
			// Store data, already forwarded
			writeDataMem <= srcB;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////
	dataMemory #(
		.dmemDepth(dmemDepth)
	) u_dataMemory (
		.clk(clk),
		.writeEn(memWriteMem && running),
		.addr(aluOutMem[pcWidth-1:0]),
		.writeData(writeDataMem),
		.readData(readDataMem)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			memToRegWb <= 1'b0;
			regWriteWb <= 1'b0;
			eopWb <= 1'b0;
			writeRegWb <= '0;
		end else if (running) begin
			memToRegWb <= memToRegMem;
			regWriteWb <= regWriteMem;
			eopWb <= eopMem;
			writeRegWb <= writeRegMem;
		end
	end

	always_ff @(posedge clk) begin
		if (running) begin
			aluOutWb <= aluOutMem;
			readDataWb <= readDataMem;
		end
	end

	assign resultWb = memToRegWb ? readDataWb : aluOutWb;

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic           clk,
	input  logic           rst,
	input  logic           writeEn,
	input  fabPkg::RegAddr writeAddr,
	input  fabPkg::Word    writeData,
	input  fabPkg::RegAddr readAddrA,
	input  fabPkg::RegAddr readAddrB,
	input  fabPkg::RegAddr dbgAddr,
	output fabPkg::Word    readDataA,
	output fabPkg::Word    readDataB,
	output fabPkg::Word    dbgData
);
	import fabPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	Word regs [numRegs];
	logic writing;

	// Register 0 is never written, so it stays zero from reset
	assign writing = writeEn && (writeAddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writing) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through, covers WB to ID
	assign readDataA = (writing && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writing && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	assign dbgData = regs[dbgAddr];

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tbMipsPipeline -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- tbMipsPipeline.sv
`timescale 1ns/1ps

module tbMipsPipeline;
	import fabPkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 8;
	localparam int numPrograms = 4;
	localparam int memDepth = 256;
	localparam int numRegs = 32;

	logic clk = 1'b0;
	logic rst;
	logic loadReq;
	Pc loadAddr;
	Word loadData;
	logic loadAck;
	logic start;
	logic halted;
	RegAddr dbgRegAddr;
	Word dbgRegData;

	int valueErrors = 0;
	int protocolErrors = 0;
	integer seed = 63366;

	// Program under construction and the reference machine state
	Word prog[$];
	Word progMem [memDepth] = '{default: '0};
	Word modelMem [memDepth] = '{default: '0};
	Word modelRegs [numRegs];

	mipsPipeline #(
		.imemDepth(memDepth),
		.dmemDepth(memDepth)
	) u_mipsPipeline (
		.clk(clk),
		.rst(rst),
		.loadReq(loadReq),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.loadAck(loadAck),
		.start(start),
		.halted(halted),
		.dbgRegAddr(dbgRegAddr),
		.dbgRegData(dbgRegData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////////////////////////
	assert property (@(posedge clk) rst |=> !loadAck)
		else begin
			$display("Load acknowledge was high right after reset at %0t", $time);
			protocolErrors++;
		end

	assert property (@(posedge clk) $rose(loadAck) |-> $past(loadReq))
		else begin
			$display("Load acknowledge rose without a load request at %0t", $time);
			protocolErrors++;
		end

	assert property (@(posedge clk) $fell(loadAck) |-> !$past(loadReq))
		else begin
			$display("Load acknowledge fell while the request was still up at %0t", $time);
			protocolErrors++;
		end

	assert property (@(posedge clk) rst |=> !halted)
		else begin
			$display("Core reported halted right after reset at %0t", $time);
			protocolErrors++;
		end

	// Once halted, only reset clears it
	assert property (@(posedge clk) (halted && !rst) |=> halted)
		else begin
			$display("Halted dropped without a reset at %0t", $time);
			protocolErrors++;
		end

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////
	function automatic Word rtype(Funct fn, int rd, int rs, int rt);
		return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic Word immOp(Opcode op, int rt, int rs, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// Offset counts from PC+1
	function automatic Word jumpBy(int offset);
		return {opJ, 10'd0, 16'(offset)};
	endfunction

	function automatic Word haltWord();
		return {opEop, 26'd0};
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic void writeModelReg(RegAddr r, Word v);
		if (r != '0) begin
			modelRegs[r] = v;
		end
	endfunction

	task automatic runModel(input int progId);
		Pc pc;
		Word ins;
		Word a;
		Word b;
		Word imm;
		Opcode op;
		RegAddr rs;
		RegAddr rt;
		RegAddr rd;
		int steps;
		logic done;
		for (int i = 0; i < numRegs; i++) begin
			modelRegs[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 2000) begin
			ins = progMem[pc];
			op = Opcode'(ins[31:26]);
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			a = modelRegs[rs];
			b = modelRegs[rt];
			imm = {{16{ins[15]}}, ins[15:0]};
			pc = pc + Pc'(1);
			steps++;
			case (op)
				opRtype: begin
					case (Funct'(ins[5:0]))
						fnAdd: writeModelReg(rd, a + b);
						fnSub: writeModelReg(rd, a - b);
						fnAnd: writeModelReg(rd, a & b);
						fnOr: writeModelReg(rd, a | b);
						fnXor: writeModelReg(rd, a ^ b);
						fnSlt: writeModelReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				end
				opAddi: writeModelReg(rt, a + imm);
				opLw: writeModelReg(rt, modelMem[Pc'(a + imm)]);
				opSw: modelMem[Pc'(a + imm)] = b;
				opBeq: begin
					if (a == b) begin
						pc = pc + imm[pcWidth-1:0];
					end
				end
				opBne: begin
					if (a != b) begin
						pc = pc + imm[pcWidth-1:0];
					end
				end
				opJ: pc = pc + imm[pcWidth-1:0];
				opEop: done = 1'b1;
				default: ;
			endcase
		end
		if (!done) begin
			$display("Reference model for program %0d never reached EOP", progId);
			protocolErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////
	task automatic aluChain();
		prog.delete();
		prog.push_back(immOp(opAddi, 1, 0, 5));
		prog.push_back(immOp(opAddi, 2, 1, -3));
		prog.push_back(rtype(fnAdd, 3, 1, 2));
		prog.push_back(rtype(fnSub, 4, 3, 1));
		prog.push_back(rtype(fnAnd, 5, 4, 3));
		prog.push_back(rtype(fnOr, 6, 5, 1));
		prog.push_back(rtype(fnXor, 7, 6, 3));
		prog.push_back(rtype(fnSlt, 8, 4, 1));
		prog.push_back(rtype(fnSlt, 9, 1, 4));
		// Writes to r0 must vanish
		prog.push_back(immOp(opAddi, 0, 1, 7));
		prog.push_back(rtype(fnAdd, 10, 0, 1));
		prog.push_back(rtype(fnSub, 11, 0, 1));
		prog.push_back(rtype(fnSlt, 12, 11, 1));
		prog.push_back(haltWord());
		prog.push_back(immOp(opAddi, 13, 0, 99));
	endtask

	task automatic memoryProgram();
		prog.delete();
		prog.push_back(immOp(opAddi, 1, 0, 10));
		prog.push_back(immOp(opAddi, 2, 0, 1234));
		prog.push_back(immOp(opSw, 2, 1, 0));
		prog.push_back(immOp(opSw, 1, 1, 5));
		prog.push_back(immOp(opLw, 3, 1, 0));
		prog.push_back(rtype(fnAdd, 4, 3, 3));
		// Loaded value used as an address, then as store data
		prog.push_back(immOp(opLw, 5, 1, 5));
		prog.push_back(immOp(opLw, 6, 5, 0));
		prog.push_back(immOp(opSw, 6, 0, 2));
		prog.push_back(immOp(opLw, 7, 0, 2));
		prog.push_back(rtype(fnSub, 8, 7, 4));
		prog.push_back(immOp(opAddi, 9, 0, -7));
		prog.push_back(immOp(opSw, 9, 0, 3));
		prog.push_back(immOp(opLw, 10, 0, 3));
		prog.push_back(rtype(fnSlt, 11, 10, 0));
		prog.push_back(haltWord());
	endtask

	task automatic branchProgram();
		prog.delete();
		prog.push_back(immOp(opAddi, 1, 0, 3));
		prog.push_back(immOp(opAddi, 2, 0, 3));
		prog.push_back(immOp(opBeq, 2, 1, 1));
		prog.push_back(immOp(opAddi, 10, 0, 111));
		prog.push_back(immOp(opBne, 2, 1, 5));
		prog.push_back(immOp(opSw, 1, 0, 20));
		// Branch right behind a load
		prog.push_back(immOp(opLw, 4, 0, 20));
		prog.push_back(immOp(opBeq, 1, 4, 2));
		prog.push_back(immOp(opAddi, 11, 0, 1));
		prog.push_back(immOp(opAddi, 12, 0, 2));
		prog.push_back(immOp(opAddi, 5, 0, -1));
		prog.push_back(immOp(opBne, 1, 5, 1));
		prog.push_back(immOp(opAddi, 13, 0, 3));
		prog.push_back(jumpBy(2));
		prog.push_back(immOp(opAddi, 14, 0, 4));
		prog.push_back(immOp(opAddi, 15, 0, 5));
		prog.push_back(immOp(opBeq, 1, 5, 4));
		// Backward loop of three passes
		prog.push_back(immOp(opAddi, 7, 7, 1));
		prog.push_back(immOp(opBne, 1, 7, -2));
		prog.push_back(jumpBy(1));
		prog.push_back(immOp(opAddi, 16, 0, 6));
		prog.push_back(immOp(opLw, 8, 0, 20));
		prog.push_back(rtype(fnAdd, 9, 0, 0));
		prog.push_back(immOp(opBne, 0, 8, 1));
		prog.push_back(immOp(opAddi, 17, 0, 9));
		prog.push_back(haltWord());
		prog.push_back(immOp(opAddi, 18, 0, 1));
	endtask

	task automatic randomProgram();
		Funct fnList [6];
		int rd;
		int rs;
		int rt;
		int pick;
		fnList = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt};
		prog.delete();
		for (int i = 0; i < 40; i++) begin
			// Few registers, so most instructions depend on recent ones
			rd = $unsigned($random(seed)) % 12;
			rs = $unsigned($random(seed)) % 12;
			rt = $unsigned($random(seed)) % 12;
			pick = $unsigned($random(seed)) % 12;
			if (pick < 6) begin
				prog.push_back(immOp(opAddi, rd, rs, $random(seed)));
			end else begin
				prog.push_back(rtype(fnList[pick - 6], rd, rs, rt));
			end
		end
		prog.push_back(haltWord());
	endtask

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (resetCycles) tick();
		rst = 1'b0;
		assert (!loadAck && !halted) else begin
			$display("Load acknowledge or halted not low after reset at %0t", $time);
			protocolErrors++;
		end
	endtask

	// Four-phase handshake per word
	task automatic loadProgram();
		foreach (prog[i]) begin
			loadAddr = Pc'(i);
			loadData = prog[i];
			loadReq = 1'b1;
			progMem[i] = prog[i];
			do tick(); while (!loadAck);
			// Request held a little past the acknowledge on some words
			repeat (i % 3) tick();
			loadReq = 1'b0;
			do tick(); while (loadAck);
		end
	endtask

	task automatic compareRegs(input int progId);
		for (int i = 0; i < numRegs; i++) begin
			dbgRegAddr = RegAddr'(i);
			#2;
			assert (dbgRegData === modelRegs[i]) else begin
				$display("MISMATCH @%0t: program %0d r%0d is %h, expected %h",
					$time, progId, i, dbgRegData, modelRegs[i]);
				valueErrors++;
			end
			tick();
		end
	endtask

	task automatic runProgram(input int progId);
		applyReset();
		loadProgram();
		assert (!halted) else begin
			$display("Core halted before start in program %0d", progId);
			protocolErrors++;
		end
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!halted) tick();
		// Nothing may retire after EOP
		repeat (4) tick();
		runModel(progId);
		compareRegs(progId);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		rst = 1'b1;
		loadReq = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		dbgRegAddr = '0;
		tick();
		aluChain();
		runProgram(0);
		memoryProgram();
		runProgram(1);
		branchProgram();
		runProgram(2);
		randomProgram();
		runProgram(3);
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(numPrograms * 200 * clkPeriod);
		$display("Timeout: the programs did not finish in %0d cycles", numPrograms * 200);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
